// File: rtl/iccm_pkg.sv
package iccm_pkg;

   // ********************
   // ICCM geometry
   // ********************
   localparam int ICCM_BITS       = 12;
   localparam int ICCM_NUM_BANKS  = 8;
   localparam int ICCM_BANK_BITS  = 3;
   localparam int ICCM_BANK_HI    = 4;
   localparam int ICCM_INDEX_BITS = 7;
   localparam int ICCM_GROUPS     = ICCM_NUM_BANKS / 4;

   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;
   localparam int CODE_W = DATA_W + ECC_W;

   // Register offsets, valid when PADDR bit ICCM_BITS is set
   localparam logic [ICCM_BITS-1:0] REG_INJECT    = 'h0;
   localparam logic [ICCM_BITS-1:0] REG_SEC_COUNT = 'h4;
   localparam logic [ICCM_BITS-1:0] REG_CTRL      = 'h8;

   typedef struct packed {
      logic [ECC_W-1:0]  ecc;
      logic [DATA_W-1:0] data;
   } ecc_word_t;

   typedef struct packed {
      logic                 wren;
      logic                 rden;
      logic [ICCM_BITS-1:2] addr;
      ecc_word_t            wr_data;
   } iccm_req_t;

   typedef struct packed {
      ecc_word_t hi1;
      ecc_word_t hi0;
      ecc_word_t lo1;
      ecc_word_t lo0;
   } iccm_row_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              sec;
      logic              ded;
   } ecc_result_t;

   // ********************
   // SEC-DED Hamming code
   // ********************

   // Data bits sit on the non power of two positions 3..38
   function automatic logic [ECC_W-2:0] ecc_hamming(input logic [DATA_W-1:0] d);
      logic [ECC_W-2:0] h;
      int unsigned      j;
      h = '0;
      j = 0;
      for (int unsigned p = 1; p < CODE_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int unsigned k = 0; k < ECC_W - 1; k++) begin
               if (p[k]) begin
                  h[k] ^= d[j];
               end
            end
            j++;
         end
      end
      return h;
   endfunction

   function automatic ecc_word_t ecc_encode(input logic [DATA_W-1:0] d);
      ecc_word_t w;
      w.data             = d;
      w.ecc[ECC_W-2:0]   = ecc_hamming(d);
      // Overall parity makes the full codeword even
      w.ecc[ECC_W-1]     = ^{w.ecc[ECC_W-2:0], d};
      return w;
   endfunction

   function automatic logic [ECC_W-1:0] ecc_syndrome(input ecc_word_t w);
      logic [ECC_W-1:0] s;
      s[ECC_W-2:0] = ecc_hamming(w.data) ^ w.ecc[ECC_W-2:0];
      s[ECC_W-1]   = ^w;
      return s;
   endfunction

endpackage

// File: rtl/iccm_clk_gate.sv
module iccm_clk_gate (
   input  logic clk,
   input  logic en,
   input  logic override,
   output logic gclk
);

   logic en_latch;

   // Transparent while clk is low so the enable settles before the rising edge
   always_latch begin
      if (!clk) begin
         en_latch <= en | override;
      end
   end

   assign gclk = clk & en_latch;

endmodule

// File: rtl/iccm_sram.sv
module iccm_sram #(
   parameter int DEPTH = 128,
   parameter int WIDTH = 39
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  logic [WIDTH-1:0]         d,
   output logic [WIDTH-1:0]         q
);

   logic [WIDTH-1:0] mem [DEPTH];

   // Write cycles leave q holding the last read
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;
      end else begin
         q <= mem[addr];
      end
   end

endmodule

// File: rtl/iccm_mem.sv
module iccm_mem (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                clk_override,
   input  iccm_pkg::iccm_req_t req,
   output iccm_pkg::iccm_row_t rd_row
);

   // Lane order within a group is lo0, lo1, hi0, hi1 (address bits 3:2)
   iccm_pkg::ecc_word_t dout [iccm_pkg::ICCM_GROUPS][4];

   logic [iccm_pkg::ICCM_BANK_HI-4:0] grp_q;
   logic [iccm_pkg::ICCM_INDEX_BITS-1:0] row_addr;

   assign row_addr = req.addr[iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_BITS+2];

   // ********************
   // Bank groups
   // ********************
   for (genvar g = 0; g < iccm_pkg::ICCM_GROUPS; g++) begin : g_group
      logic grp_hit;

      assign grp_hit = (req.addr[iccm_pkg::ICCM_BANK_HI:4] == g);

      for (genvar l = 0; l < 4; l++) begin : g_lane
         logic lane_we;
         logic clken;
         logic gclk;

         assign lane_we = req.wren & grp_hit & (req.addr[3:2] == l);
         // A read of the group wakes all four lanes
         assign clken   = lane_we | (req.rden & grp_hit);

         iccm_clk_gate u_clk_gate (
            .clk      (clk),
            .en       (clken),
            .override (clk_override),
            .gclk     (gclk)
         );

         iccm_sram #(
            .DEPTH (2 ** iccm_pkg::ICCM_INDEX_BITS),
            .WIDTH (iccm_pkg::CODE_W)
         ) u_sram (
            .clk  (gclk),
            .we   (lane_we),
            .addr (row_addr),
            .d    (req.wr_data),
            .q    (dout[g][l])
         );
      end
   end

   // ********************
   // Read data steering
   // ********************

   // Group of the last read, held on the ungated clock
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         grp_q <= '0;
      end else if (req.rden) begin
         grp_q <= req.addr[iccm_pkg::ICCM_BANK_HI:4];
      end
   end

   assign rd_row.lo0 = dout[grp_q][0];
   assign rd_row.lo1 = dout[grp_q][1];
   assign rd_row.hi0 = dout[grp_q][2];
   assign rd_row.hi1 = dout[grp_q][3];

   a_no_rw_collision : assert property (@(posedge clk) disable iff (!arst_n)
      !(req.wren && req.rden));

endmodule

// File: rtl/iccm_ecc_check.sv
module iccm_ecc_check (
   input  iccm_pkg::ecc_word_t   word,
   output iccm_pkg::ecc_result_t result
);

   logic [iccm_pkg::ECC_W-1:0]  syn;
   logic [iccm_pkg::DATA_W-1:0] data_fix;
   logic                        in_range;
   logic                        sec;
   logic                        ded;

   assign syn = iccm_pkg::ecc_syndrome(word);

   // Position 0 is the overall parity bit, 1..38 the Hamming layout
   assign in_range = (syn[iccm_pkg::ECC_W-2:0] < iccm_pkg::CODE_W);

   // Odd overall parity means one flipped bit
   assign sec = syn[iccm_pkg::ECC_W-1] & in_range;
   assign ded = (syn != '0) & ~sec;

   // ********************
   // Correction
   // ********************
   always_comb begin
      int unsigned j;
      j        = 0;
      data_fix = word.data;
      for (int unsigned p = 1; p < iccm_pkg::CODE_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (sec && (syn[iccm_pkg::ECC_W-2:0] == p[iccm_pkg::ECC_W-2:0])) begin
               data_fix[j] = ~word.data[j];
            end
            j++;
         end
      end
   end

   assign result.data = data_fix;
   assign result.sec  = sec;
   assign result.ded  = ded;

endmodule

// File: rtl/iccm_apb_ctrl.sv
module iccm_apb_ctrl (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [iccm_pkg::ICCM_BITS:0]  paddr,
   input  logic [iccm_pkg::DATA_W-1:0]   pwdata,
   output logic [iccm_pkg::DATA_W-1:0]   prdata,
   output logic                          pready,
   output logic                          pslverr,
   output iccm_pkg::iccm_req_t           req,
   output logic                          clk_override,
   input  iccm_pkg::iccm_row_t           rd_row,
   output iccm_pkg::ecc_word_t           check_word,
   input  iccm_pkg::ecc_result_t         check_result
);

   logic                                access;
   logic                                is_reg;
   logic                                reg_wr;
   logic                                wren;
   logic                                rden;
   logic                                rd_wait;
   logic [1:0]                          lane_q;
   logic [iccm_pkg::ICCM_BITS-1:0]      reg_off;
   logic [iccm_pkg::DATA_W-1:0]         inject_q;
   logic [15:0]                         sec_count_q;
   logic                                ctrl_q;
   iccm_pkg::ecc_word_t                 enc_word;

   // ********************
   // APB access decode
   // ********************
   assign access  = psel & penable;
   assign is_reg  = paddr[iccm_pkg::ICCM_BITS];
   assign reg_off = paddr[iccm_pkg::ICCM_BITS-1:0];
   assign reg_wr  = access & pwrite & is_reg;
   assign wren    = access & pwrite & ~is_reg;
   // Array reads issue once, in the first access cycle
   assign rden    = access & ~pwrite & ~is_reg & ~rd_wait;

   assign pready  = (access & (pwrite | is_reg)) | rd_wait;
   assign pslverr = rd_wait & check_result.ded;

   // ********************
   // Memory request
   // ********************
   assign enc_word = iccm_pkg::ecc_encode(pwdata);

   always_comb begin
      req.wren         = wren;
      req.rden         = rden;
      req.addr         = paddr[iccm_pkg::ICCM_BITS-1:2];
      req.wr_data.ecc  = enc_word.ecc;
      // Injection flips data bits after the check bits are computed
      req.wr_data.data = enc_word.data ^ inject_q;
   end

   assign clk_override = ctrl_q;

   always_ff @(posedge clk) begin
      if (rden) begin
         lane_q <= paddr[3:2];
      end
   end

   always_comb begin
      case (lane_q)
         2'd0:    check_word = rd_row.lo0;
         2'd1:    check_word = rd_row.lo1;
         2'd2:    check_word = rd_row.hi0;
         default: check_word = rd_row.hi1;
      endcase
   end

   // ********************
   // Control registers
   // ********************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_wait     <= 1'b0;
         inject_q    <= '0;
         ctrl_q      <= 1'b0;
         sec_count_q <= '0;
      end else begin
         rd_wait <= rden;
         if (reg_wr && (reg_off == iccm_pkg::REG_INJECT)) begin
            inject_q <= pwdata;
         end
         if (reg_wr && (reg_off == iccm_pkg::REG_CTRL)) begin
            ctrl_q <= pwdata[0];
         end
         // Saturates at all ones
         if (rd_wait && check_result.sec && (sec_count_q != '1)) begin
            sec_count_q <= sec_count_q + 1'b1;
         end
      end
   end

   always_comb begin
      prdata = '0;
      if (rd_wait) begin
         prdata = check_result.data;
      end else if (access && is_reg && !pwrite) begin
         case (reg_off)
            iccm_pkg::REG_INJECT:    prdata = inject_q;
            iccm_pkg::REG_SEC_COUNT: prdata[15:0] = sec_count_q;
            iccm_pkg::REG_CTRL:      prdata[0] = ctrl_q;
            default:                 prdata = '0;
         endcase
      end
   end

   a_pready_in_access : assert property (@(posedge clk) disable iff (!arst_n)
      pready |-> (psel && penable));

   a_read_one_wait : assert property (@(posedge clk) disable iff (!arst_n)
      (psel && $rose(penable) && !pwrite && !is_reg) |-> (req.rden && !pready ##1 pready));

endmodule

// File: rtl/iccm_top.sv
module iccm_top (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [iccm_pkg::ICCM_BITS:0] paddr,
   input  logic [iccm_pkg::DATA_W-1:0]  pwdata,
   output logic [iccm_pkg::DATA_W-1:0]  prdata,
   output logic                         pready,
   output logic                         pslverr
);

   iccm_pkg::iccm_req_t   req;
   iccm_pkg::iccm_row_t   rd_row;
   iccm_pkg::ecc_word_t   check_word;
   iccm_pkg::ecc_result_t check_result;
   logic                  clk_override;

   iccm_apb_ctrl u_ctrl (
      .clk          (clk),
      .arst_n       (arst_n),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .req          (req),
      .clk_override (clk_override),
      .rd_row       (rd_row),
      .check_word   (check_word),
      .check_result (check_result)
   );

   iccm_mem u_mem (
      .clk          (clk),
      .arst_n       (arst_n),
      .clk_override (clk_override),
      .req          (req),
      .rd_row       (rd_row)
   );

   iccm_ecc_check u_check (
      .word   (check_word),
      .result (check_result)
   );

endmodule

// File: tb/iccm_tb.sv
module iccm_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // Transfers issued by all tests together, used to size the watchdog
   localparam int NUM_XFERS  = 468;
   localparam int TIMEOUT_NS = NUM_XFERS * 10 * 4 + 10 * 4;

   logic        clk;
   logic        arst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [12:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   // Expected response of the current read
   logic [31:0] exp_data;
   logic        exp_err;
   logic        chk_data;

   logic [31:0] model [int];
   int          sec_model;
   int          addr_q [$];
   int          errors;
   int          err_mark;
   int          tests_passed;
   int          tests_failed;

   iccm_top u_iccm_top (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
      $display("Regression failed");
      $finish;
   end

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("FAIL %s expected %h got %h", sig, exp, act);
      errors++;
   endtask

   task automatic note_error(input string msg);
      $display("Error: %s", msg);
      errors++;
   endtask

   // ********************
   // Checking assertions
   // ********************
   a_idle_quiet : assert property (@(posedge clk)
      !(psel && penable) |-> (!pready && !pslverr))
      else note_error("pready or pslverr high outside an access phase");

   a_rdata : assert property (@(posedge clk) disable iff (!arst_n)
      (psel && penable && pready && !pwrite && chk_data) |-> (prdata == exp_data))
      else report_mismatch("prdata", $sampled(exp_data), $sampled(prdata));

   a_rerr : assert property (@(posedge clk) disable iff (!arst_n)
      (psel && penable && pready && !pwrite) |-> (pslverr == exp_err))
      else report_mismatch("pslverr", $sampled(exp_err), $sampled(pslverr));

   a_no_wait : assert property (@(posedge clk) disable iff (!arst_n)
      (psel && $rose(penable) && (pwrite || paddr[12])) |-> pready)
      else note_error("write or register access took a wait state");

   a_one_wait : assert property (@(posedge clk) disable iff (!arst_n)
      (psel && $rose(penable) && !pwrite && !paddr[12]) |-> (!pready ##1 pready))
      else note_error("array read did not finish in its second access cycle");

   // ********************
   // APB stimulus
   // ********************
   function automatic logic [12:0] arr_addr(input logic [9:0] w);
      return {1'b0, w, 2'b00};
   endfunction

   function automatic logic [12:0] reg_addr(input logic [11:0] off);
      return {1'b1, off};
   endfunction

   task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      while (!pready) begin
         @(posedge clk);
      end
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic read_expect(input logic [12:0] addr, input logic [31:0] exp,
                              input logic err, input logic use_data);
      exp_data = exp;
      exp_err  = err;
      chk_data = use_data;
      apb_xfer(1'b0, addr, '0);
   endtask

   // One word written through a given inject mask, then checked
   task automatic injected_word(input logic [31:0] mask, input logic ded);
      logic [9:0]  w;
      logic [31:0] d;
      w = 10'($urandom);
      d = $urandom;
      apb_xfer(1'b1, reg_addr(iccm_pkg::REG_INJECT), mask);
      apb_xfer(1'b1, arr_addr(w), d);
      apb_xfer(1'b1, reg_addr(iccm_pkg::REG_INJECT), '0);
      if (ded) begin
         model.delete(w);
         read_expect(arr_addr(w), '0, 1'b1, 1'b0);
      end else begin
         model[w] = d;
         sec_model++;
         read_expect(arr_addr(w), d, 1'b0, 1'b1);
      end
      read_expect(reg_addr(iccm_pkg::REG_SEC_COUNT), sec_model, 1'b0, 1'b1);
   endtask

   task automatic finish_test(input string name);
      if (errors == err_mark) begin
         tests_passed++;
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   initial begin
      logic [9:0]  w;
      logic [31:0] d;
      int          b1;
      arst_n   = 1'b0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      exp_data = '0;
      exp_err  = 1'b0;
      chk_data = 1'b0;
      void'($urandom(32'hde37_8bd0));
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      read_expect(reg_addr(iccm_pkg::REG_INJECT), '0, 1'b0, 1'b1);
      read_expect(reg_addr(iccm_pkg::REG_SEC_COUNT), '0, 1'b0, 1'b1);
      read_expect(reg_addr(iccm_pkg::REG_CTRL), '0, 1'b0, 1'b1);
      finish_test("reset");

      // First eight words hit every lane of both groups
      for (int i = 0; i < 200; i++) begin
         w = (i < 8) ? 10'(i) : 10'($urandom);
         d = $urandom;
         model[w] = d;
         apb_xfer(1'b1, arr_addr(w), d);
      end
      foreach (model[k]) begin
         read_expect(arr_addr(k[9:0]), model[k], 1'b0, 1'b1);
      end
      finish_test("round trip and handshake");

      for (int i = 0; i < 4; i++) begin
         injected_word(32'h1 << ($urandom % 32), 1'b0);
      end
      finish_test("single error correction");

      for (int i = 0; i < 2; i++) begin
         b1 = $urandom % 32;
         injected_word((32'h1 << b1) | (32'h1 << ((b1 + 1 + $urandom % 31) % 32)), 1'b1);
      end
      finish_test("double error detection");

      apb_xfer(1'b1, reg_addr(iccm_pkg::REG_CTRL), 32'h1);
      read_expect(reg_addr(iccm_pkg::REG_CTRL), 32'h1, 1'b0, 1'b1);
      for (int i = 0; i < 16; i++) begin
         w = 10'($urandom);
         d = $urandom;
         model[w] = d;
         addr_q.push_back(w);
         apb_xfer(1'b1, arr_addr(w), d);
      end
      foreach (addr_q[i]) begin
         read_expect(arr_addr(addr_q[i][9:0]), model[addr_q[i]], 1'b0, 1'b1);
      end
      apb_xfer(1'b1, reg_addr(iccm_pkg::REG_CTRL), '0);
      finish_test("clock override");

      repeat (4) @(posedge clk);
      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: src.f
rtl/iccm_pkg.sv
rtl/iccm_clk_gate.sv
rtl/iccm_sram.sv
rtl/iccm_mem.sv
rtl/iccm_ecc_check.sv
rtl/iccm_apb_ctrl.sv
rtl/iccm_top.sv
tb/iccm_tb.sv

// File: Bender.yml
package:
  name: iccm

sources:
  - rtl/iccm_pkg.sv
  - rtl/iccm_clk_gate.sv
  - rtl/iccm_sram.sv
  - rtl/iccm_mem.sv
  - rtl/iccm_ecc_check.sv
  - rtl/iccm_apb_ctrl.sv
  - rtl/iccm_top.sv
  - target: test
    files:
      - tb/iccm_tb.sv
